//--- all.f
hdl/rv_core_pkg.sv
hdl/alu.sv
hdl/imm_gen.sv
hdl/regfile.sv
hdl/control_fsm.sv
hdl/datapath.sv
hdl/rv_core_top.sv
verification/rv_core_properties.sv
verification/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module rv_core_tb -f all.f -o rv_core_sim

./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
	exit 0
fi
exit 1

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

	// own encodings, kept apart from the design package
	localparam logic [6:0] OP_R      = 7'h33;
	localparam logic [6:0] OP_I      = 7'h13;
	localparam logic [6:0] OP_LUI    = 7'h37;
	localparam logic [6:0] OP_LOAD   = 7'h03;
	localparam logic [6:0] OP_STORE  = 7'h23;
	localparam logic [6:0] OP_BRANCH = 7'h63;
	localparam logic [6:0] OP_JAL    = 7'h6f;
	localparam logic [6:0] OP_JALR   = 7'h67;

	localparam int OPN_ADD  = 0;
	localparam int OPN_SUB  = 1;
	localparam int OPN_AND  = 2;
	localparam int OPN_OR   = 3;
	localparam int OPN_SLT  = 4;
	localparam int OPN_ADDI = 5;

	localparam logic [31:0] FIRST_PC   = 32'h0000_0000;
	localparam int          MAX_STORES = 64;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_wdata;
	logic [31:0] wb_rdata;
	logic        wb_ack;

	logic [31:0] mem [256];
	logic [31:0] exp_addr [MAX_STORES];
	logic [31:0] exp_data [MAX_STORES];
	string       exp_name [MAX_STORES];
	int          n_expected;
	int          n_checked = 0;
	int          pc_w;
	logic [31:0] res_addr;
	int          cycle_limit = 0;
	int          cycles = 0;
	logic        first_seen = 1'b0;

	rv_core_top u_dut (
		.clk      (clk),
		.i_rst_n  (rst_n),
		.o_wb_cyc (wb_cyc),
		.o_wb_stb (wb_stb),
		.o_wb_we  (wb_we),
		.o_wb_adr (wb_adr),
		.o_wb_dat (wb_wdata),
		.i_wb_dat (wb_rdata),
		.i_wb_ack (wb_ack)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type_word(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] b_type_word(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] j_type_word(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	// expected value of one operation, straight from the isa rules
	function automatic logic [31:0] ref_result(input int op, input logic [31:0] a,
			input logic [31:0] b);
		case (op)
			OPN_ADD, OPN_ADDI: return a + b;
			OPN_SUB:           return a - b;
			OPN_AND:           return a & b;
			OPN_OR:            return a | b;
			OPN_SLT:           return {31'b0, $signed(a) < $signed(b)};
			default:           return 32'h0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic emit(input logic [31:0] word);
		mem[pc_w[7:0]] = word;
		pc_w++;
	endtask

	// lui + addi, upper part rounded for the sign of the low 12 bits
	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] hi;
		hi = value + 32'h800;
		emit({hi[31:12], rd, OP_LUI});
		emit(i_type_word(value[11:0], rd, 3'b000, rd, OP_I));
	endtask

	// sw rs2 to the next result slot, off x0
	task automatic emit_store(input logic [4:0] rs2, input logic expected,
			input logic [31:0] value, input string name);
		emit(s_type_word(res_addr[11:0], rs2, 5'd0));
		if (expected) begin
			exp_addr[n_expected] = res_addr;
			exp_data[n_expected] = value;
			exp_name[n_expected] = name;
			n_expected++;
		end
		res_addr += 32'd4;
	endtask

	task automatic build_program();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] opnd_b;
		logic [31:0] r;
		logic [31:0] lui_val;
		logic [31:0] load_addr;
		logic [31:0] jal_pc;
		logic [31:0] jalr_pc;
		logic [31:0] target;
		logic [6:0]  f7;
		logic [2:0]  f3;
		string       label;
		int          op;
		for (int i = 0; i < 256; i++)
			mem[i] = 32'h0; // opcode 0 runs as a no-op
		pc_w       = 0;
		n_expected = 0;
		res_addr   = 32'h280;
		for (int pair = 0; pair < 16; pair++) begin
			a = $urandom;
			b = $urandom;
			load_const(5'd1, a);
			load_const(5'd2, b);
			for (int k = 0; k < 2; k++) begin
				op = $urandom_range(5, 0);
				f7 = 7'h00;
				f3 = 3'b000;
				case (op)
					OPN_ADD: label = "add";
					OPN_SUB: begin
						f7    = 7'h20;
						label = "sub";
					end
					OPN_AND: begin
						f3    = 3'b111;
						label = "and";
					end
					OPN_OR: begin
						f3    = 3'b110;
						label = "or";
					end
					OPN_SLT: begin
						f3    = 3'b010;
						label = "slt";
					end
					default: label = "addi";
				endcase
				if (op == OPN_ADDI) begin
					r      = $urandom;
					opnd_b = {{20{r[11]}}, r[11:0]};
					emit(i_type_word(r[11:0], 5'd1, 3'b000, 5'd3, OP_I));
				end else begin
					opnd_b = b;
					emit({f7, 5'd2, 5'd1, f3, 5'd3, OP_R});
				end
				emit_store(5'd3, 1'b1, ref_result(op, a, opnd_b),
					$sformatf("%s %0d", label, pair * 2 + k));
			end
		end

		// lui, then a load of the stored word written back out
		lui_val = $urandom;
		emit({lui_val[19:0], 5'd4, OP_LUI});
		load_addr = res_addr;
		emit_store(5'd4, 1'b1, {lui_val[19:0], 12'h000}, "lui upper immediate");
		emit(i_type_word(load_addr[11:0], 5'd0, 3'b010, 5'd5, OP_LOAD));
		emit_store(5'd5, 1'b1, {lui_val[19:0], 12'h000}, "lw of stored word");

		emit(i_type_word(12'd5, 5'd0, 3'b000, 5'd6, OP_I));
		emit(b_type_word(13'd8, 5'd6, 5'd6)); // taken, skips the marker
		emit_store(5'd6, 1'b0, 32'h0, "");
		emit_store(5'd6, 1'b1, 32'd5, "store after taken beq");
		emit(b_type_word(13'd8, 5'd0, 5'd6)); // 5 != 0, falls through
		emit_store(5'd6, 1'b1, 32'd5, "marker after non-taken beq");

		jal_pc = pc_w * 4;
		emit(j_type_word(21'd8, 5'd8));
		emit_store(5'd0, 1'b0, 32'h0, "");
		emit_store(5'd8, 1'b1, jal_pc + 32'd4, "jal link");

		jalr_pc = (pc_w + 1) * 4;
		target  = jalr_pc + 32'd8;
		emit(i_type_word(target[11:0], 5'd0, 3'b000, 5'd9, OP_I));
		emit(i_type_word(12'd0, 5'd9, 3'b000, 5'd10, OP_JALR));
		emit_store(5'd0, 1'b0, 32'h0, "");
		emit_store(5'd10, 1'b1, jalr_pc + 32'd4, "jalr link");

		emit(j_type_word(21'd0, 5'd0)); // spin here
		cycle_limit = pc_w * 20 + 100;
	endtask

	// wishbone slave memory, 0 to 3 wait cycles per request
	initial begin
		int wait_left;
		wait_left = -1;
		wb_ack    = 1'b0;
		wb_rdata  = 32'h0;
		void'($urandom(54));
		build_program();
		forever begin
			@(negedge clk);
			if (wb_cyc && wb_stb && wb_ack && wb_we)
				mem[wb_adr[9:2]] = wb_wdata;
			@(posedge clk);
			#0.5;
			if (wb_ack) begin
				wb_ack    = 1'b0;
				wait_left = -1;
			end else if (wb_cyc && wb_stb) begin
				if (wait_left < 0)
					wait_left = $urandom_range(3, 0);
				if (wait_left == 0) begin
					wb_ack   = 1'b1;
					wb_rdata = mem[wb_adr[9:2]];
				end else
					wait_left--;
			end
		end
	end

	// acknowledged writes against the expected store sequence
	always @(negedge clk) begin
		if (rst_n && wb_stb && !first_seen) begin
			check_value("first fetch address", FIRST_PC, wb_adr);
			check_value("first fetch write enable", 32'h0, {31'b0, wb_we});
			check_value("first fetch cycle", 32'h1, {31'b0, wb_cyc});
			first_seen = 1'b1;
		end
		if (wb_cyc && wb_stb && wb_ack && wb_we) begin
			if (n_checked >= n_expected) begin
				$display("unexpected write of %h to address %h", wb_wdata, wb_adr);
				$display("Test failed");
				$fatal(1, "stray bus write");
			end else begin
				check_value({exp_name[n_checked], " address"}, exp_addr[n_checked], wb_adr);
				check_value({exp_name[n_checked], " data"}, exp_data[n_checked], wb_wdata);
				n_checked++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("run did not finish within %0d cycles", cycle_limit);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#0.5;
		rst_n = 1'b1;
		while (n_checked < n_expected)
			@(posedge clk);
		repeat (40) @(posedge clk); // halt loop, a late store would still show up
		if (!first_seen) begin
			$display("no bus cycle was seen after reset");
			$display("Test failed");
			$fatal(1, "no fetch");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

//--- verification/rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties (
	input logic                         clk,
	input logic                         i_rst_n,
	input logic                         o_wb_cyc,
	input logic                         o_wb_stb,
	input logic                         o_wb_we,
	input logic [rv_core_pkg::XLEN-1:0] o_wb_adr,
	input logic [rv_core_pkg::XLEN-1:0] o_wb_dat,
	input logic                         i_wb_ack
);

	stb_within_cyc: assert property (@(posedge clk) o_wb_stb |-> o_wb_cyc)
		else $error("wishbone stb high without cyc");

	// request held until the slave answers
	request_held: assert property (@(posedge clk) disable iff (!i_rst_n)
		(o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr) && $stable(o_wb_we)))
		else $error("wishbone request changed before ack");

	// write data only matters on writes
	write_data_held: assert property (@(posedge clk) disable iff (!i_rst_n)
		(o_wb_stb && o_wb_we && !i_wb_ack) |=> $stable(o_wb_dat))
		else $error("wishbone write data changed before ack");

	// single beat, the cycle closes right after its ack
	cycle_ends_on_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
		(o_wb_stb && i_wb_ack) |=> (!o_wb_stb && !o_wb_cyc))
		else $error("wishbone cycle still open after ack");

	quiet_in_reset: assert property (@(posedge clk) !i_rst_n |=> !o_wb_stb)
		else $error("wishbone request while in reset");

endmodule

bind rv_core_top rv_core_properties u_props (.*);

//--- hdl/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
	input  logic                         clk,
	input  logic                         i_rst_n,
	output logic                         o_wb_cyc,
	output logic                         o_wb_stb,
	output logic                         o_wb_we,
	output logic [rv_core_pkg::XLEN-1:0] o_wb_adr,
	output logic [rv_core_pkg::XLEN-1:0] o_wb_dat,
	input  logic [rv_core_pkg::XLEN-1:0] i_wb_dat,
	input  logic                         i_wb_ack
);

	rv_core_pkg::instr_u instr;

	logic                             ir_we;
	logic                             mdr_we;
	logic                             pc_write;
	logic                             branch;
	logic [rv_core_pkg::ALU_OP_W-1:0] alu_op;
	logic [1:0]                       src_a;
	logic [1:0]                       src_b;
	logic                             reg_we;
	logic [1:0]                       wb_sel;
	logic                             addr_result;

	control_fsm u_ctrl (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_instr       (instr),
		.i_wb_ack      (i_wb_ack),
		.o_wb_cyc      (o_wb_cyc),
		.o_wb_stb      (o_wb_stb),
		.o_wb_we       (o_wb_we),
		.o_ir_we       (ir_we),
		.o_mdr_we      (mdr_we),
		.o_pc_write    (pc_write),
		.o_branch      (branch),
		.o_alu_op      (alu_op),
		.o_src_a       (src_a),
		.o_src_b       (src_b),
		.o_reg_we      (reg_we),
		.o_wb_sel      (wb_sel),
		.o_addr_result (addr_result)
	);

	datapath u_dp (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_ir_we       (ir_we),
		.i_mdr_we      (mdr_we),
		.i_pc_write    (pc_write),
		.i_branch      (branch),
		.i_alu_op      (alu_op),
		.i_src_a       (src_a),
		.i_src_b       (src_b),
		.i_reg_we      (reg_we),
		.i_wb_sel      (wb_sel),
		.i_addr_result (addr_result),
		.i_wb_dat      (i_wb_dat),
		.o_instr       (instr),
		.o_wb_adr      (o_wb_adr),
		.o_wb_dat      (o_wb_dat)
	);

endmodule

//--- hdl/datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic                             clk,
	input  logic                             i_rst_n,
	input  logic                             i_ir_we,
	input  logic                             i_mdr_we,
	input  logic                             i_pc_write,
	input  logic                             i_branch,
	input  logic [rv_core_pkg::ALU_OP_W-1:0] i_alu_op,
	input  logic [1:0]                       i_src_a,
	input  logic [1:0]                       i_src_b,
	input  logic                             i_reg_we,
	input  logic [1:0]                       i_wb_sel,
	input  logic                             i_addr_result,
	input  logic [rv_core_pkg::XLEN-1:0]     i_wb_dat,
	output rv_core_pkg::instr_u              o_instr,
	output logic [rv_core_pkg::XLEN-1:0]     o_wb_adr,
	output logic [rv_core_pkg::XLEN-1:0]     o_wb_dat
);

	rv_core_pkg::instr_u instr_q;

	logic [rv_core_pkg::XLEN-1:0] pc_q;
	logic [rv_core_pkg::XLEN-1:0] old_pc_q;
	logic [rv_core_pkg::XLEN-1:0] a_q;
	logic [rv_core_pkg::XLEN-1:0] b_q;
	logic [rv_core_pkg::XLEN-1:0] result_q;
	logic [rv_core_pkg::XLEN-1:0] mdr_q;
	logic [rv_core_pkg::XLEN-1:0] rd1;
	logic [rv_core_pkg::XLEN-1:0] rd2;
	logic [rv_core_pkg::XLEN-1:0] imm;
	logic [rv_core_pkg::XLEN-1:0] alu_a;
	logic [rv_core_pkg::XLEN-1:0] alu_b;
	logic [rv_core_pkg::XLEN-1:0] alu_result;
	logic [rv_core_pkg::XLEN-1:0] wb_data;
	logic [rv_core_pkg::XLEN-1:0] pc_next;
	logic                         alu_zero;
	logic                         pc_en;

	assign o_instr  = instr_q;
	assign o_wb_adr = i_addr_result ? result_q : pc_q;
	assign o_wb_dat = b_q; // store data is rs2

	// branch selects the saved target, and is conditional unless pc_write is set too
	assign pc_en   = i_pc_write | (i_branch & alu_zero);
	assign pc_next = i_branch ? result_q : alu_result;

	always_ff @(posedge clk) begin
		if (!i_rst_n)
			pc_q <= rv_core_pkg::RESET_PC;
		else if (pc_en)
			pc_q <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (i_ir_we) begin
			instr_q  <= i_wb_dat;
			old_pc_q <= pc_q; // address of this instruction
		end
		if (i_mdr_we)
			mdr_q <= i_wb_dat;
		a_q      <= rd1;
		b_q      <= rd2;
		result_q <= alu_result;
	end

	always_comb begin
		case (i_src_a)
			rv_core_pkg::SRC_A_OLD_PC: alu_a = old_pc_q;
			rv_core_pkg::SRC_A_RS1:    alu_a = a_q;
			rv_core_pkg::SRC_A_PC:     alu_a = pc_q;
			default:                   alu_a = '0;
		endcase
		case (i_src_b)
			rv_core_pkg::SRC_B_RS2:  alu_b = b_q;
			rv_core_pkg::SRC_B_FOUR: alu_b = 32'd4;
			rv_core_pkg::SRC_B_IMM:  alu_b = imm;
			default:                 alu_b = '0;
		endcase
		case (i_wb_sel)
			rv_core_pkg::WB_RESULT: wb_data = result_q;
			rv_core_pkg::WB_PC:     wb_data = pc_q; // link, already pc + 4
			rv_core_pkg::WB_MEM:    wb_data = mdr_q;
			default:                wb_data = imm;
		endcase
	end

	regfile u_rf (
		.clk   (clk),
		.i_we  (i_reg_we),
		.i_rs1 (instr_q.r.rs1),
		.i_rs2 (instr_q.r.rs2),
		.i_rd  (instr_q.r.rd),
		.i_wd  (wb_data),
		.o_rd1 (rd1),
		.o_rd2 (rd2)
	);

	alu u_alu (
		.i_a      (alu_a),
		.i_b      (alu_b),
		.i_op     (i_alu_op),
		.o_result (alu_result),
		.o_zero   (alu_zero)
	);

	imm_gen u_imm (
		.i_instr (instr_q),
		.o_imm   (imm)
	);

endmodule

//--- hdl/control_fsm.sv
`timescale 1ns/1ps

module control_fsm (
	input  logic                             clk,
	input  logic                             i_rst_n,
	input  rv_core_pkg::instr_u              i_instr,
	input  logic                             i_wb_ack,
	output logic                             o_wb_cyc,
	output logic                             o_wb_stb,
	output logic                             o_wb_we,
	output logic                             o_ir_we,
	output logic                             o_mdr_we,
	output logic                             o_pc_write,
	output logic                             o_branch,
	output logic [rv_core_pkg::ALU_OP_W-1:0] o_alu_op,
	output logic [1:0]                       o_src_a,
	output logic [1:0]                       o_src_b,
	output logic                             o_reg_we,
	output logic [1:0]                       o_wb_sel,
	output logic                             o_addr_result
);

	logic [rv_core_pkg::STG_W-1:0]    stage_q;
	logic                             stb_q;
	logic                             we_q;
	logic [rv_core_pkg::ALU_OP_W-1:0] r_op;
	logic [6:0]                       opcode;
	logic                             bus_done;

	assign opcode   = i_instr.r.opcode;
	assign bus_done = stb_q & i_wb_ack;

	assign o_wb_cyc = stb_q; // single-beat cycles, cyc follows stb
	assign o_wb_stb = stb_q;
	assign o_wb_we  = we_q;

	// r-type funct decode
	always_comb begin
		case (i_instr.r.funct3)
			3'b000:  r_op = i_instr.r.funct7[5] ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
			3'b010:  r_op = rv_core_pkg::ALU_SLT;
			3'b110:  r_op = rv_core_pkg::ALU_OR;
			3'b111:  r_op = rv_core_pkg::ALU_AND;
			default: r_op = rv_core_pkg::ALU_ADD;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			stage_q <= rv_core_pkg::STG_FETCH;
			stb_q   <= 1'b0;
			we_q    <= 1'b0;
		end else begin
			case (stage_q)
				rv_core_pkg::STG_FETCH: begin
					if (!stb_q)
						stb_q <= 1'b1; // after reset or a store
					else if (i_wb_ack) begin
						stb_q   <= 1'b0;
						stage_q <= rv_core_pkg::STG_DECODE;
					end
				end
				rv_core_pkg::STG_DECODE: stage_q <= rv_core_pkg::STG_EXECUTE;
				rv_core_pkg::STG_EXECUTE: begin
					case (opcode)
						rv_core_pkg::OPC_RTYPE,
						rv_core_pkg::OPC_ITYPE: stage_q <= rv_core_pkg::STG_WRITEBACK;
						rv_core_pkg::OPC_LOAD,
						rv_core_pkg::OPC_STORE: begin
							stage_q <= rv_core_pkg::STG_MEM;
							stb_q   <= 1'b1;
							we_q    <= (opcode == rv_core_pkg::OPC_STORE);
						end
						default: begin // jumps, beq, lui, unknown
							stage_q <= rv_core_pkg::STG_FETCH;
							stb_q   <= 1'b1;
						end
					endcase
				end
				rv_core_pkg::STG_MEM: begin
					if (i_wb_ack) begin
						stb_q   <= 1'b0;
						we_q    <= 1'b0;
						stage_q <= (opcode == rv_core_pkg::OPC_LOAD) ?
							rv_core_pkg::STG_WRITEBACK : rv_core_pkg::STG_FETCH;
					end
				end
				rv_core_pkg::STG_WRITEBACK: begin
					stage_q <= rv_core_pkg::STG_FETCH;
					stb_q   <= 1'b1;
				end
				default: stage_q <= rv_core_pkg::STG_FETCH;
			endcase
		end
	end

	always_comb begin
		o_ir_we       = 1'b0;
		o_mdr_we      = 1'b0;
		o_pc_write    = 1'b0;
		o_branch      = 1'b0;
		o_alu_op      = rv_core_pkg::ALU_ADD;
		o_src_a       = rv_core_pkg::SRC_A_PC; // pc + 4 unless told otherwise
		o_src_b       = rv_core_pkg::SRC_B_FOUR;
		o_reg_we      = 1'b0;
		o_wb_sel      = rv_core_pkg::WB_RESULT;
		o_addr_result = 1'b0;
		case (stage_q)
			rv_core_pkg::STG_FETCH: begin
				o_ir_we    = bus_done;
				o_pc_write = bus_done;
			end
			rv_core_pkg::STG_DECODE: begin
				// branch/jal target into result reg
				o_src_a = rv_core_pkg::SRC_A_OLD_PC;
				o_src_b = rv_core_pkg::SRC_B_IMM;
			end
			rv_core_pkg::STG_EXECUTE: begin
				case (opcode)
					rv_core_pkg::OPC_RTYPE: begin
						o_src_a  = rv_core_pkg::SRC_A_RS1;
						o_src_b  = rv_core_pkg::SRC_B_RS2;
						o_alu_op = r_op;
					end
					rv_core_pkg::OPC_ITYPE,
					rv_core_pkg::OPC_LOAD,
					rv_core_pkg::OPC_STORE: begin
						o_src_a = rv_core_pkg::SRC_A_RS1;
						o_src_b = rv_core_pkg::SRC_B_IMM;
					end
					rv_core_pkg::OPC_LUI: begin
						o_reg_we = 1'b1;
						o_wb_sel = rv_core_pkg::WB_IMM;
					end
					rv_core_pkg::OPC_BRANCH: begin
						o_src_a  = rv_core_pkg::SRC_A_RS1;
						o_src_b  = rv_core_pkg::SRC_B_RS2;
						o_alu_op = rv_core_pkg::ALU_SUB;
						o_branch = 1'b1; // taken when zero
					end
					rv_core_pkg::OPC_JAL: begin
						o_branch   = 1'b1;
						o_pc_write = 1'b1;
						o_reg_we   = 1'b1;
						o_wb_sel   = rv_core_pkg::WB_PC;
					end
					rv_core_pkg::OPC_JALR: begin
						o_src_a    = rv_core_pkg::SRC_A_RS1;
						o_src_b    = rv_core_pkg::SRC_B_IMM;
						o_pc_write = 1'b1;
						o_reg_we   = 1'b1;
						o_wb_sel   = rv_core_pkg::WB_PC;
					end
					default: ;
				endcase
			end
			rv_core_pkg::STG_MEM: begin
				// keep rs1 + imm so the result reg holds the address
				o_src_a       = rv_core_pkg::SRC_A_RS1;
				o_src_b       = rv_core_pkg::SRC_B_IMM;
				o_addr_result = 1'b1;
				o_mdr_we      = bus_done & (opcode == rv_core_pkg::OPC_LOAD);
			end
			rv_core_pkg::STG_WRITEBACK: begin
				o_reg_we = 1'b1;
				o_wb_sel = (opcode == rv_core_pkg::OPC_LOAD) ?
					rv_core_pkg::WB_MEM : rv_core_pkg::WB_RESULT;
			end
			default: ;
		endcase
	end

endmodule

//--- hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic                               clk,
	input  logic                               i_we,
	input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_rs1,
	input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_rs2,
	input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_rd,
	input  logic [rv_core_pkg::XLEN-1:0]       i_wd,
	output logic [rv_core_pkg::XLEN-1:0]       o_rd1,
	output logic [rv_core_pkg::XLEN-1:0]       o_rd2
);

	logic [rv_core_pkg::XLEN-1:0] regs [2**rv_core_pkg::REG_ADDR_W];

	// x0 reads as zero
	assign o_rd1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rd2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

	always_ff @(posedge clk) begin
		if (i_we && i_rd != '0)
			regs[i_rd] <= i_wd;
	end

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
	input  rv_core_pkg::instr_u          i_instr,
	output logic [rv_core_pkg::XLEN-1:0] o_imm
);

	always_comb begin
		case (i_instr.r.opcode)
			rv_core_pkg::OPC_LOAD,
			rv_core_pkg::OPC_ITYPE,
			rv_core_pkg::OPC_JALR:
				o_imm = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
			rv_core_pkg::OPC_STORE:
				o_imm = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
			// b format reuses the s fields, bit 11 sits in imm_lo[0]
			rv_core_pkg::OPC_BRANCH:
				o_imm = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_lo[0],
					i_instr.s.imm_hi[5:0], i_instr.s.imm_lo[4:1], 1'b0};
			// j format scrambled inside the u field
			rv_core_pkg::OPC_JAL:
				o_imm = {{12{i_instr.u.imm[19]}}, i_instr.u.imm[7:0], i_instr.u.imm[8],
					i_instr.u.imm[18:9], 1'b0};
			rv_core_pkg::OPC_LUI:
				o_imm = {i_instr.u.imm, 12'b0};
			default:
				o_imm = '0;
		endcase
	end

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [rv_core_pkg::XLEN-1:0]     i_a,
	input  logic [rv_core_pkg::XLEN-1:0]     i_b,
	input  logic [rv_core_pkg::ALU_OP_W-1:0] i_op,
	output logic [rv_core_pkg::XLEN-1:0]     o_result,
	output logic                             o_zero
);

	always_comb begin
		case (i_op)
			rv_core_pkg::ALU_ADD: o_result = i_a + i_b;
			rv_core_pkg::ALU_SUB: o_result = i_a - i_b;
			rv_core_pkg::ALU_AND: o_result = i_a & i_b;
			rv_core_pkg::ALU_OR:  o_result = i_a | i_b;
			rv_core_pkg::ALU_SLT: begin
				o_result = '0;
				o_result[0] = ($signed(i_a) < $signed(i_b));
			end
			default: o_result = '0;
		endcase
	end

	assign o_zero = (o_result == '0); // beq compares via sub

endmodule

//--- hdl/rv_core_pkg.sv
package rv_core_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// major opcodes
	localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
	localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	localparam int ALU_OP_W = 3;
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
	localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd4;

	// first alu operand
	localparam logic [1:0] SRC_A_OLD_PC = 2'd0;
	localparam logic [1:0] SRC_A_RS1    = 2'd1;
	localparam logic [1:0] SRC_A_PC     = 2'd2;

	// second alu operand
	localparam logic [1:0] SRC_B_RS2  = 2'd0;
	localparam logic [1:0] SRC_B_FOUR = 2'd1;
	localparam logic [1:0] SRC_B_IMM  = 2'd2;

	// register write-back source
	localparam logic [1:0] WB_RESULT = 2'd0;
	localparam logic [1:0] WB_PC     = 2'd1;
	localparam logic [1:0] WB_MEM    = 2'd2;
	localparam logic [1:0] WB_IMM    = 2'd3;

	// sequencer stages
	localparam int STG_W = 3;
	localparam logic [STG_W-1:0] STG_FETCH     = 3'd0;
	localparam logic [STG_W-1:0] STG_DECODE    = 3'd1;
	localparam logic [STG_W-1:0] STG_EXECUTE   = 3'd2;
	localparam logic [STG_W-1:0] STG_MEM       = 3'd3;
	localparam logic [STG_W-1:0] STG_WRITEBACK = 3'd4;

	// one instruction word, seen through each encoding format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
	} instr_u;

endpackage
